/* hdl/soml_pkg.sv */
package soml_pkg;

  // --------------------------------------------------------------------------
  // Dimensions
  // --------------------------------------------------------------------------

  // Width of one real or imaginary part
  parameter int sample_w = 32;

  // Channel matrix is mat_dim x mat_dim, stored row-major
  parameter int mat_dim   = 4;
  parameter int h_entries = mat_dim * mat_dim;

  // Received vector, split in two halves
  parameter int y_half    = 4;
  parameter int y_entries = 2 * y_half;

  // Lanes per packed row towards the matrix multiplier
  parameter int lanes = 2 * mat_dim;

  // Debug select width
  parameter int sel_w = 6;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  typedef struct packed {
    logic [sample_w-1:0] re;
    logic [sample_w-1:0] im;
  } cplx_t;

  // One input stream beat, counted when valid is high at a clock edge
  typedef struct packed {
    logic  valid;
    cplx_t data;
  } sample_strobe_t;

  // Lanes 2j and 2j+1 of row k both carry H[j][k]
  typedef cplx_t [lanes-1:0] h_row_t;
  typedef h_row_t [mat_dim-1:0] h_rows_t;

  // Pair handed out per step, y1 from half one and y2 from half two
  typedef struct packed {
    cplx_t y1;
    cplx_t y2;
  } y_pair_t;

  typedef struct packed {
    logic       imag;
    logic       is_y;
    logic [1:0] row;
    logic [1:0] col;
  } dbg_sel_t;

endpackage

/* hdl/input_sync.sv */
`timescale 1ns/1ps

module input_sync
  import soml_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           start_i,
  input  sample_strobe_t h_i,
  input  sample_strobe_t y_i,
  output logic           start_o,
  output sample_strobe_t h_o,
  output sample_strobe_t y_o
);

  // One stage holds start and both streams so they stay aligned
  typedef struct packed {
    logic           start;
    sample_strobe_t h;
    sample_strobe_t y;
  } stage_t;

  stage_t stage_q [SYNC_STAGES];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= '{start: start_i, h: h_i, y: y_i};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign start_o = stage_q[SYNC_STAGES-1].start;
  assign h_o     = stage_q[SYNC_STAGES-1].h;
  assign y_o     = stage_q[SYNC_STAGES-1].y;

  // A zero-depth chain would leave the outputs undriven
  if (SYNC_STAGES < 1) begin : g_stages_check
    $error("SYNC_STAGES must be at least one");
  end

endmodule

/* hdl/load_ctrl.sv */
`timescale 1ns/1ps

module load_ctrl
  import soml_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_i,
  input  sample_strobe_t               h_i,
  input  sample_strobe_t               y_i,
  output logic                         h_we_o,
  output logic [$clog2(h_entries)-1:0] h_idx_o,
  output logic                         y_we_o,
  output logic [$clog2(y_entries)-1:0] y_idx_o,
  output cplx_t                        wr_data_h_o,
  output cplx_t                        wr_data_y_o,
  output logic                         hq_start_o,
  output logic                         restart_o
);

  typedef enum logic {
    ST_IDLE,
    ST_LOAD
  } state_t;

  state_t                       state_q;
  logic [$clog2(h_entries)-1:0] h_cnt_q;
  logic [$clog2(y_entries)-1:0] y_cnt_q;
  logic                         hq_start_q;
  logic                         h_last;

  // --------------------------------------------------------------------------
  // Write steering
  // --------------------------------------------------------------------------

  // Start wins over a sample seen in the same cycle
  assign h_we_o = (state_q == ST_LOAD) && h_i.valid && !start_i;
  assign y_we_o = (state_q == ST_LOAD) && y_i.valid && !start_i;

  assign h_idx_o     = h_cnt_q;
  assign y_idx_o     = y_cnt_q;
  assign wr_data_h_o = h_i.data;
  assign wr_data_y_o = y_i.data;

  // Both states accept start
  assign restart_o = start_i;

  // Last H entry of the matrix
  assign h_last = h_we_o && (h_cnt_q == h_entries - 1);

  // --------------------------------------------------------------------------
  // State and counters
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      h_cnt_q    <= '0;
      y_cnt_q    <= '0;
      hq_start_q <= 1'b0;
    end else begin
      hq_start_q <= h_last;
      if (start_i) begin
        state_q <= ST_LOAD;
        h_cnt_q <= '0;
        y_cnt_q <= '0;
      end else if (state_q == ST_LOAD) begin
        if (h_we_o) begin
          h_cnt_q <= h_cnt_q + 1'b1;
        end
        if (h_last) begin
          state_q <= ST_IDLE;
        end
        // Y index wraps from the last entry back to zero
        if (y_we_o) begin
          y_cnt_q <= y_cnt_q + 1'b1;
        end
      end
    end
  end

  assign hq_start_o = hq_start_q;

  // Multiplier start is a single-cycle pulse
  a_hq_start_pulse: assert property (
    @(posedge clk) disable iff (rst) hq_start_o |=> !hq_start_o
  );

  // An H write needs a start before it and no last entry in between
  a_h_we_in_load: assert property (
    @(posedge clk) disable iff (rst)
    h_we_o |-> $past(start_i) || $past(state_q == ST_LOAD && !h_last)
  );

endmodule

/* hdl/channel_store.sv */
`timescale 1ns/1ps

module channel_store
  import soml_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         we_i,
  input  logic [$clog2(h_entries)-1:0] idx_i,
  input  cplx_t                        data_i,
  input  logic                         hq_start_i,
  input  dbg_sel_t                     dbg_i,
  output h_rows_t                      hq_rows_o,
  output logic [sample_w-1:0]          dbg_o
);

  // Row-major, entry r*mat_dim + c holds H[r][c]
  cplx_t   h_mem [h_entries];
  h_rows_t rows_next;
  h_rows_t rows_q;
  cplx_t   dbg_entry;

  // --------------------------------------------------------------------------
  // Matrix memory
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < h_entries; i++) begin
        h_mem[i] <= '0;
      end
    end else if (we_i) begin
      h_mem[idx_i] <= data_i;
    end
  end

  // --------------------------------------------------------------------------
  // Row packing for the multiplier
  // --------------------------------------------------------------------------

  // Row k carries column k of H, each entry on two neighbouring lanes
  always_comb begin
    for (int k = 0; k < mat_dim; k++) begin
      for (int j = 0; j < mat_dim; j++) begin
        rows_next[k][2*j]   = h_mem[j*mat_dim + k];
        rows_next[k][2*j+1] = h_mem[j*mat_dim + k];
      end
    end
  end

  // Packing is taken once per matrix and then held for the multiplier
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rows_q <= '0;
    end else if (hq_start_i) begin
      rows_q <= rows_next;
    end
  end

  assign hq_rows_o = rows_q;

  // --------------------------------------------------------------------------
  // Debug read
  // --------------------------------------------------------------------------

  assign dbg_entry = h_mem[{dbg_i.row, dbg_i.col}];
  assign dbg_o     = dbg_i.imag ? dbg_entry.im : dbg_entry.re;

endmodule

/* hdl/rx_vector_store.sv */
`timescale 1ns/1ps

module rx_vector_store
  import soml_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         we_i,
  input  logic [$clog2(y_entries)-1:0] idx_i,
  input  cplx_t                        data_i,
  input  logic                         restart_i,
  input  logic                         y_step_i,
  input  dbg_sel_t                     dbg_i,
  output y_pair_t                      y_pair_o,
  output logic [sample_w-1:0]          dbg_o
);

  // Half one holds samples 0..3, half two holds 4..7
  cplx_t                      y_mem1 [y_half];
  cplx_t                      y_mem2 [y_half];
  cplx_t                      conj_data;
  logic [$clog2(y_half)-1:0]  step_q;
  logic [$clog2(y_entries)-1:0] dbg_idx;
  cplx_t                      dbg_entry;

  // Samples are kept as their conjugate
  assign conj_data = '{re: data_i.re, im: -data_i.im};

  // --------------------------------------------------------------------------
  // Store
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < y_half; i++) begin
        y_mem1[i] <= '0;
        y_mem2[i] <= '0;
      end
    end else if (we_i) begin
      if (idx_i[2]) begin
        y_mem2[idx_i[1:0]] <= conj_data;
      end else begin
        y_mem1[idx_i[1:0]] <= conj_data;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Step sequencer
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      step_q <= '0;
    end else if (restart_i) begin
      step_q <= '0;
    end else if (y_step_i) begin
      step_q <= step_q + 1'b1;
    end
  end

  // Zero whenever no step is requested
  assign y_pair_o = y_step_i ? '{y1: y_mem1[step_q], y2: y_mem2[step_q]} : '0;

  // Debug read, one list of eight indexed by row and the high col bit
  assign dbg_idx   = {dbg_i.row, dbg_i.col[1]};
  assign dbg_entry = dbg_idx[2] ? y_mem2[dbg_idx[1:0]] : y_mem1[dbg_idx[1:0]];
  assign dbg_o     = dbg_i.imag ? dbg_entry.im : dbg_entry.re;

  // Write index must name exactly one of the eight entries
  a_idx_known: assert property (
    @(posedge clk) disable iff (rst) we_i |-> !$isunknown(idx_i)
  );

endmodule

/* hdl/soml_frontend_top.sv */
`timescale 1ns/1ps

module soml_frontend_top
  import soml_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start_i,
  input  sample_strobe_t      h_in_i,
  input  sample_strobe_t      y_in_i,
  input  logic                y_step_i,
  input  dbg_sel_t            dbg_sel_i,
  output logic                hq_start_o,
  output h_rows_t             hq_rows_o,
  output y_pair_t             y_pair_o,
  output logic [sample_w-1:0] dbg_data_o
);

  logic                         start_d;
  sample_strobe_t               h_d;
  sample_strobe_t               y_d;
  logic                         h_we;
  logic [$clog2(h_entries)-1:0] h_idx;
  logic                         y_we;
  logic [$clog2(y_entries)-1:0] y_idx;
  cplx_t                        wr_data_h;
  cplx_t                        wr_data_y;
  logic                         restart;
  logic [sample_w-1:0]          dbg_h;
  logic [sample_w-1:0]          dbg_y;

  // Debug select layout must match its declared width
  if ($bits(dbg_sel_t) != sel_w) begin : g_sel_check
    $error("dbg_sel_t width does not match sel_w");
  end

  input_sync #(.SYNC_STAGES(SYNC_STAGES)) input_sync_inst (
    .clk    (clk),
    .rst    (rst),
    .start_i(start_i),
    .h_i    (h_in_i),
    .y_i    (y_in_i),
    .start_o(start_d),
    .h_o    (h_d),
    .y_o    (y_d)
  );

  load_ctrl load_ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start_d),
    .h_i        (h_d),
    .y_i        (y_d),
    .h_we_o     (h_we),
    .h_idx_o    (h_idx),
    .y_we_o     (y_we),
    .y_idx_o    (y_idx),
    .wr_data_h_o(wr_data_h),
    .wr_data_y_o(wr_data_y),
    .hq_start_o (hq_start_o),
    .restart_o  (restart)
  );

  channel_store channel_store_inst (
    .clk       (clk),
    .rst       (rst),
    .we_i      (h_we),
    .idx_i     (h_idx),
    .data_i    (wr_data_h),
    .hq_start_i(hq_start_o),
    .dbg_i     (dbg_sel_i),
    .hq_rows_o (hq_rows_o),
    .dbg_o     (dbg_h)
  );

  // y_step_i stands in for the downstream G-valid
  rx_vector_store rx_vector_store_inst (
    .clk      (clk),
    .rst      (rst),
    .we_i     (y_we),
    .idx_i    (y_idx),
    .data_i   (wr_data_y),
    .restart_i(restart),
    .y_step_i (y_step_i),
    .dbg_i    (dbg_sel_i),
    .y_pair_o (y_pair_o),
    .dbg_o    (dbg_y)
  );

  assign dbg_data_o = dbg_sel_i.is_y ? dbg_y : dbg_h;

endmodule

/* test/soml_checker.sv */
`timescale 1ns/1ps

module soml_checker
  import soml_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start_i,
  input  sample_strobe_t      h_in_i,
  input  sample_strobe_t      y_in_i,
  input  logic                y_step_i,
  input  dbg_sel_t            dbg_sel_i,
  input  logic                hq_start_i,
  input  h_rows_t             hq_rows_i,
  input  y_pair_t             y_pair_i,
  input  logic [sample_w-1:0] dbg_data_i,
  input  int                  test_id_i,
  input  logic                test_end_i,
  output int                  tests_failed_o,
  output int                  errors_o
);

  // One beat as the stores see it once it has left the input registers
  typedef struct packed {
    logic       restart;
    logic       h_we;
    logic       h_last;
    logic [3:0] h_idx;
    cplx_t      h_data;
    logic       y_we;
    logic [2:0] y_idx;
    cplx_t      y_data;
  } beat_t;

  beat_t               pipe [SYNC_STAGES+1];
  beat_t               new_beat;
  beat_t               due_beat;
  cplx_t               h_vis [h_entries];
  cplx_t               y_vis [y_entries];
  cplx_t               sel_entry;
  h_rows_t             exp_rows;
  y_pair_t             exp_pair;
  logic [sample_w-1:0] exp_dbg;
  logic                exp_hq;
  logic                loading;
  int                  h_cnt;
  int                  y_cnt;
  int                  step;
  int                  test_errs;
  int                  errors;
  int                  tests_failed;

  assign errors_o       = errors + test_errs;
  assign tests_failed_o = tests_failed;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "H load and row packing";
      3: return "Y conjugation and stepping";
      4: return "debug readback";
      5: return "restart mid-load";
      default: return "unknown";
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Output comparison against the visible model state
  // --------------------------------------------------------------------------

  task automatic compare_outputs();
    if (hq_start_i !== exp_hq) begin
      $display("[FAIL] hq_start_o exp %h got %h", exp_hq, hq_start_i);
      test_errs++;
    end
    if (hq_rows_i !== exp_rows) begin
      for (int k = 0; k < mat_dim; k++) begin
        for (int l = 0; l < lanes; l++) begin
          if (hq_rows_i[k][l] !== exp_rows[k][l]) begin
            $display("[FAIL] hq_rows_o[%0d][%0d] exp %h got %h", k, l,
                     exp_rows[k][l], hq_rows_i[k][l]);
          end
        end
      end
      test_errs++;
    end
    // Pair is (y[c], y[c+4]) while stepping, zero otherwise
    exp_pair = '0;
    if (y_step_i) begin
      exp_pair.y1 = y_vis[step];
      exp_pair.y2 = y_vis[step + y_half];
    end
    if (y_pair_i !== exp_pair) begin
      $display("[FAIL] y_pair_o exp %h got %h", exp_pair, y_pair_i);
      test_errs++;
    end
    if (dbg_sel_i.is_y) begin
      sel_entry = y_vis[dbg_sel_i.row * 2 + dbg_sel_i.col[1]];
    end else begin
      sel_entry = h_vis[dbg_sel_i.row * mat_dim + dbg_sel_i.col];
    end
    exp_dbg = dbg_sel_i.imag ? sel_entry.im : sel_entry.re;
    if (dbg_data_i !== exp_dbg) begin
      $display("[FAIL] dbg_data_o exp %h got %h", exp_dbg, dbg_data_i);
      test_errs++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Model update, one step per clock edge
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i <= SYNC_STAGES; i++) begin
        pipe[i] = '0;
      end
      for (int i = 0; i < h_entries; i++) begin
        h_vis[i] = '0;
      end
      for (int i = 0; i < y_entries; i++) begin
        y_vis[i] = '0;
      end
      exp_rows     = '0;
      exp_hq       = 1'b0;
      loading      = 1'b0;
      h_cnt        = 0;
      y_cnt        = 0;
      step         = 0;
      test_errs    = 0;
      errors       = 0;
      tests_failed = 0;
    end else begin
      compare_outputs();
      // Packing is taken from the matrix as it stands during the pulse
      if (exp_hq) begin
        for (int k = 0; k < mat_dim; k++) begin
          for (int l = 0; l < lanes; l++) begin
            exp_rows[k][l] = h_vis[(l / 2) * mat_dim + k];
          end
        end
      end

      // Beat accepted at the DUT inputs, start taking priority
      new_beat = '0;
      if (start_i) begin
        loading          = 1'b1;
        h_cnt            = 0;
        y_cnt            = 0;
        new_beat.restart = 1'b1;
      end else if (loading) begin
        if (y_in_i.valid) begin
          new_beat.y_we      = 1'b1;
          new_beat.y_idx     = 3'(y_cnt);
          new_beat.y_data.re = y_in_i.data.re;
          new_beat.y_data.im = -y_in_i.data.im;
          y_cnt              = (y_cnt + 1) % y_entries;
        end
        if (h_in_i.valid) begin
          new_beat.h_we   = 1'b1;
          new_beat.h_idx  = 4'(h_cnt);
          new_beat.h_data = h_in_i.data;
          new_beat.h_last = (h_cnt == h_entries - 1);
          h_cnt++;
          if (new_beat.h_last) begin
            loading = 1'b0;
          end
        end
      end

      for (int i = SYNC_STAGES; i > 0; i--) begin
        pipe[i] = pipe[i-1];
      end
      pipe[0]  = new_beat;
      due_beat = pipe[SYNC_STAGES];

      // Beat reaches the stores after the input register latency
      if (due_beat.h_we) begin
        h_vis[due_beat.h_idx] = due_beat.h_data;
      end
      if (due_beat.y_we) begin
        y_vis[due_beat.y_idx] = due_beat.y_data;
      end
      exp_hq = due_beat.h_last;
      if (due_beat.restart) begin
        step = 0;
      end else if (y_step_i) begin
        step = (step + 1) % y_half;
      end

      if (test_end_i) begin
        if (test_errs == 0) begin
          $display("test %0d, %s: passed", test_id_i, test_name(test_id_i));
        end else begin
          $display("test %0d, %s: failed with %0d errors", test_id_i,
                   test_name(test_id_i), test_errs);
          tests_failed++;
        end
        errors    = errors + test_errs;
        test_errs = 0;
      end
    end
  end

endmodule

/* test/tb_soml_frontend.sv */
`timescale 1ns/1ps

module tb_soml_frontend
  import soml_pkg::*;
();

  localparam int SYNC_STAGES     = 2;
  localparam int NUM_TESTS       = 5;
  localparam int MAX_TEST_CYCLES = 150;
  localparam int TIMEOUT_NS      = NUM_TESTS * MAX_TEST_CYCLES * 4 * 2;

  logic                clk;
  logic                rst;
  logic                start;
  sample_strobe_t      h_in;
  sample_strobe_t      y_in;
  logic                y_step;
  dbg_sel_t            dbg_sel;
  logic                hq_start;
  h_rows_t             hq_rows;
  y_pair_t             y_pair;
  logic [sample_w-1:0] dbg_data;
  int                  test_id;
  logic                test_end;
  int                  tests_failed;
  int                  errors;
  int                  other_errs;
  logic [31:0]         lfsr_state;

  always #2 clk = ~clk;

  soml_frontend_top #(.SYNC_STAGES(SYNC_STAGES)) soml_frontend_top_inst (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start),
    .h_in_i    (h_in),
    .y_in_i    (y_in),
    .y_step_i  (y_step),
    .dbg_sel_i (dbg_sel),
    .hq_start_o(hq_start),
    .hq_rows_o (hq_rows),
    .y_pair_o  (y_pair),
    .dbg_data_o(dbg_data)
  );

  soml_checker #(.SYNC_STAGES(SYNC_STAGES)) soml_checker_inst (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start),
    .h_in_i        (h_in),
    .y_in_i        (y_in),
    .y_step_i      (y_step),
    .dbg_sel_i     (dbg_sel),
    .hq_start_i    (hq_start),
    .hq_rows_i     (hq_rows),
    .y_pair_i      (y_pair),
    .dbg_data_i    (dbg_data),
    .test_id_i     (test_id),
    .test_end_i    (test_end),
    .tests_failed_o(tests_failed),
    .errors_o      (errors)
  );

  // --------------------------------------------------------------------------
  // Random bits, Galois LFSR x^32 + x^22 + x^2 + x + 1
  // --------------------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus, always entered and left on a falling edge
  // --------------------------------------------------------------------------

  // Random gap first so the wait for hq_start starts right after the beat
  task automatic drive_beat(input logic with_h, input logic with_y);
    repeat (take_bits(2)) @(negedge clk);
    h_in.valid   = with_h;
    h_in.data.re = take_bits(32);
    h_in.data.im = take_bits(32);
    y_in.valid   = with_y;
    y_in.data.re = take_bits(32);
    y_in.data.im = take_bits(32);
    dbg_sel      = sel_w'(take_bits(sel_w));
    @(negedge clk);
    h_in.valid = 1'b0;
    y_in.valid = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_for_hq_start();
    int waited;
    waited = 0;
    while (!hq_start && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (!hq_start) begin
      $display("hq_start_o did not pulse within 16 cycles of the last H sample");
      other_errs++;
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic step_randomly(input int highs);
    int seen;
    seen = 0;
    while (seen < highs) begin
      y_step  = 1'(take_bits(1));
      dbg_sel = sel_w'(take_bits(sel_w));
      if (y_step) begin
        seen++;
      end
      @(negedge clk);
    end
    y_step = 1'b0;
  endtask

  task automatic end_test(input int id);
    test_id  = id;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    h_in       = '0;
    y_in       = '0;
    y_step     = 1'b0;
    dbg_sel    = '0;
    test_id    = 0;
    test_end   = 1'b0;
    other_errs = 0;
    lfsr_state = 32'd75796;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Empty stores read back and step out as zeros
    step_randomly(3);
    end_test(1);

    // Samples ahead of the start are ignored
    repeat (3) drive_beat(1'b1, 1'b0);
    pulse_start();
    repeat (h_entries) drive_beat(1'b1, 1'b0);
    wait_for_hq_start();
    end_test(2);

    pulse_start();
    for (int i = 0; i < h_entries; i++) begin
      drive_beat(1'b1, i < y_entries);
    end
    wait_for_hq_start();
    step_randomly(5);
    end_test(3);

    repeat (32) begin
      dbg_sel = sel_w'(take_bits(sel_w));
      @(negedge clk);
    end
    end_test(4);

    pulse_start();
    repeat (7) drive_beat(1'b1, 1'b0);
    pulse_start();
    repeat (h_entries) drive_beat(1'b1, 1'b0);
    wait_for_hq_start();
    y_step = 1'b1;
    @(negedge clk);
    y_step = 1'b0;
    end_test(5);

    $display("Tests run: %0d, failed: %0d, value errors: %0d, other errors: %0d",
             NUM_TESTS, tests_failed, errors, other_errs);
    if (tests_failed == 0 && errors == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
hdl/soml_pkg.sv
hdl/input_sync.sv
hdl/load_ctrl.sv
hdl/channel_store.sv
hdl/rx_vector_store.sv
hdl/soml_frontend_top.sv
test/soml_checker.sv
test/tb_soml_frontend.sv
